// ==== src.f ====
+incdir+dv
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_regs.sv
source/uart_ser.sv
source/uart_des.sv
source/uart_peri.sv
dv/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart_peri

sources:
  # Peripheral RTL, package first
  - target: any(rtl, test)
    files:
      - source/uart_pkg.sv
      - source/uart_fifo.sv
      - source/uart_regs.sv
      - source/uart_ser.sv
      - source/uart_des.sv
      - source/uart_peri.sv

  # Testbench
  - target: test
    include_dirs:
      - dv
    files:
      - dv/uart_tb.sv

// ==== dv/uart_tb_check.svh ====
`ifndef UART_TB_CHECK_SVH
`define UART_TB_CHECK_SVH

//////////////////////////////
// Bus access
//////////////////////////////

int    pass_cnt = 0;  // Tests without errors
int    fail_cnt = 0;  // Tests with errors
int    test_errs;     // Errors in running test
string cur_test;

// Single write, bus idle afterwards
task automatic bus_write(input uart_adr_e adr, input logic [BUS_W-1:0] dat);
  @(posedge tcb);
  #1;
  bus_vld = 1'b1;
  bus_wen = 1'b1;
  bus_adr = adr;
  bus_wdt = dat;
  @(posedge tcb);  // Register takes the write here
  #1;
  bus_vld = 1'b0;
  bus_wen = 1'b0;
endtask

task automatic bus_read(input uart_adr_e adr, output logic [BUS_W-1:0] dat);
  @(posedge tcb);
  #1;
  bus_vld = 1'b1;
  bus_wen = 1'b0;
  bus_adr = adr;
  #1;
  dat = bus_rdt;  // Combinational, settled mid cycle
  @(posedge tcb);
  #1;
  bus_vld = 1'b0;
endtask

//////////////////////////////
// Test bookkeeping
//////////////////////////////

task automatic test_begin(input string name);
  cur_test  = name;
  test_errs = 0;
endtask

task automatic test_end();
  if (test_errs == 0) begin
    pass_cnt++;
    $display("Test %s passed", cur_test);
  end else begin
    fail_cnt++;
    $display("Test %s failed with %0d errors", cur_test, test_errs);
  end
endtask

// Failures that carry no value pair
task automatic report_error(input string msg);
  test_errs++;
  $display("Error in %s, %s", cur_test, msg);
endtask

task automatic check_dat(input string what, input logic [DW-1:0] exp,
                         input logic [DW-1:0] act);
  if (act !== exp) begin
    test_errs++;
    $display("Fail %s %s expected 'h%0h actual 'h%0h", cur_test, what, exp, act);
  end
endtask

task automatic check_cnt(input string what, input logic [CW-1:0] exp,
                         input logic [CW-1:0] act);
  if (act !== exp) begin
    test_errs++;
    $display("Fail %s %s expected %0d actual %0d", cur_test, what, exp, act);
  end
endtask

task automatic check_word(input string what, input logic [BUS_W-1:0] exp,
                          input logic [BUS_W-1:0] act);
  if (act !== exp) begin
    test_errs++;
    $display("Fail %s %s expected 'h%0h actual 'h%0h", cur_test, what, exp, act);
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    test_errs++;
    $display("Fail %s %s expected %b actual %b", cur_test, what, exp, act);
  end
endtask

`endif

// ==== dv/uart_tb.sv ====
`timescale 1ns/100ps

module uart_tb;

  import uart_pkg::*;

  localparam int unsigned RW     = 8;
  localparam int unsigned DW     = 8;
  localparam int unsigned SZ     = 16;
  localparam int unsigned CW     = $clog2(SZ+1);
  localparam int unsigned N_TX   = 6;  // Frames per test
  localparam int unsigned N_RX   = 6;
  localparam int unsigned N_LOOP = 6;
  localparam int unsigned POLL_MAX = (DW+2) * (2**RW);  // Reads covering one slow frame
  // Every frame at the slowest bit period twice over plus margin
  localparam longint FRAME_NS = (DW+2) * (2**RW) * 10;
  localparam longint N_FRAMES = N_TX + N_RX + 1 + SZ + 3 + N_LOOP;
  localparam longint WD_NS    = N_FRAMES * FRAME_NS * 2 + 10000;

  logic             tcb = 1'b0;
  logic             rst_n;
  logic             bus_vld;
  logic             bus_wen;
  logic [ADR_W-1:0] bus_adr;
  logic [BUS_W-1:0] bus_wdt;
  logic [BUS_W-1:0] bus_rdt;
  logic             uart_txd;
  logic             irq_tx;
  logic             irq_rx;
  wire              uart_rxd;
  logic             loop_en;  // TX line fed back to RX
  logic             gen_rxd;  // Frame generator line

  // Model
  logic [DW-1:0] tx_q[$];  // Bytes expected on uart_txd
  logic [DW-1:0] rx_q[$];  // Bytes expected from RX data
  logic [RW-1:0] sh_tx_bdr, sh_rx_bdr, sh_rx_smp;
  logic [CW-1:0] sh_tx_irq, sh_rx_irq;

  `include "uart_tb_check.svh"

  assign uart_rxd = loop_en ? uart_txd : gen_rxd;

  always #5 tcb = ~tcb;

  uart_peri #(.RW(RW), .DW(DW), .SZ(SZ)) uut (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .bus_vld  (bus_vld),
    .bus_wen  (bus_wen),
    .bus_adr  (bus_adr),
    .bus_wdt  (bus_wdt),
    .bus_rdt  (bus_rdt),
    .uart_rxd (uart_rxd),
    .uart_txd (uart_txd),
    .irq_tx   (irq_tx),
    .irq_rx   (irq_rx)
  );

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic do_reset();
    @(posedge tcb);
    #1;
    rst_n = 1'b0;
    repeat (16) @(posedge tcb);
    #1;
    rst_n = 1'b1;
    {sh_tx_bdr, sh_rx_bdr, sh_rx_smp, sh_tx_irq, sh_rx_irq} = '0;  // Config back to zero
    tx_q.delete();
    rx_q.delete();
  endtask

  // Hold one line level for n cycles
  task automatic send_bit(input logic val, input int unsigned n);
    @(posedge tcb);
    #1;
    gen_rxd = val;
    repeat (n - 1) @(posedge tcb);
  endtask

  task automatic send_frame(input logic [DW-1:0] dat, input logic stop);
    send_bit(1'b0, sh_rx_bdr + 1);  // Start
    for (int i = 0; i < DW; i++) begin
      send_bit(dat[i], sh_rx_bdr + 1);  // LSB first
    end
    send_bit(stop, sh_rx_bdr + 1);
  endtask

  task automatic wait_rx_cnt(input int unsigned target);
    int unsigned      polls;
    logic [BUS_W-1:0] cnt_rd;
    polls = 0;
    bus_read(ADR_RX_CNT, cnt_rd);
    while ((cnt_rd[CW-1:0] != CW'(target)) && (polls < POLL_MAX)) begin
      bus_read(ADR_RX_CNT, cnt_rd);
      polls++;
    end
    if (cnt_rd[CW-1:0] != CW'(target)) begin
      report_error($sformatf("RX count stuck at %0d, never reached %0d",
                             cnt_rd[CW-1:0], target));
    end
  endtask

  // Sample uart_txd mid bit clear of clock edges
  task automatic capture_frames(input int unsigned n, input int unsigned bdr);
    logic [DW-1:0] got;
    for (int f = 0; f < n; f++) begin
      @(negedge uart_txd);
      #((bdr + 1) * 5 + 2);
      check_bit("start bit", 1'b0, uart_txd);
      for (int i = 0; i < DW; i++) begin
        #((bdr + 1) * 10);
        got[i] = uart_txd;
      end
      #((bdr + 1) * 10);
      check_bit("stop bit", 1'b1, uart_txd);
      check_dat("tx byte", tx_q.pop_front(), got);
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    #(WD_NS);
    $display("Timeout, the tests did not finish within %0d ns", WD_NS);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    uart_adr_e        all_adr[9] = '{ADR_TX_DAT, ADR_TX_CNT, ADR_TX_BDR, ADR_TX_IRQ,
                                     ADR_RX_DAT, ADR_RX_CNT, ADR_RX_BDR, ADR_RX_SMP,
                                     ADR_RX_IRQ};
    uart_adr_e        cfg_adr[5] = '{ADR_TX_BDR, ADR_TX_IRQ, ADR_RX_BDR, ADR_RX_SMP,
                                     ADR_RX_IRQ};
    logic [BUS_W-1:0] cfg_val[5];
    logic [BUS_W-1:0] rd;
    logic [BUS_W-1:0] exp_w;
    logic [DW-1:0]    b;
    int unsigned      tx_load;  // Model TX FIFO load

    rst_n   = 1'b0;
    bus_vld = 1'b0;
    bus_wen = 1'b0;
    bus_adr = '0;
    bus_wdt = '0;
    gen_rxd = 1'b1;  // Idle line
    loop_en = 1'b0;
    void'($urandom(87359));
    do_reset();

    test_begin("reset");
    check_bit("uart_txd", 1'b1, uart_txd);
    check_bit("irq_tx", 1'b0, irq_tx);
    check_bit("irq_rx", 1'b0, irq_rx);
    foreach (all_adr[i]) begin
      bus_read(all_adr[i], rd);
      check_word(all_adr[i].name(), '0, rd);
    end
    test_end();

    test_begin("config");
    foreach (cfg_adr[i]) begin
      cfg_val[i] = $urandom;
      bus_write(cfg_adr[i], cfg_val[i]);
    end
    foreach (cfg_adr[i]) begin
      bus_read(cfg_adr[i], rd);
      if ((cfg_adr[i] == ADR_TX_IRQ) || (cfg_adr[i] == ADR_RX_IRQ)) begin
        exp_w = cfg_val[i] & ((BUS_W'(1) << CW) - 1);  // Level is CW wide
      end else begin
        exp_w = cfg_val[i] & ((BUS_W'(1) << RW) - 1);
      end
      check_word(cfg_adr[i].name(), exp_w, rd);
    end
    sh_tx_irq = cfg_val[1][CW-1:0];
    sh_rx_irq = cfg_val[4][CW-1:0];
    check_bit("irq_tx", (0 < sh_tx_irq), irq_tx);  // Empty TX below level
    check_bit("irq_rx", 1'b0, irq_rx);
    // TX count offset takes no write
    bus_write(ADR_TX_CNT, $urandom);
    bus_read(ADR_TX_CNT, rd);
    check_cnt("tx count", '0, rd[CW-1:0]);
    test_end();

    test_begin("transmit");
    sh_tx_bdr = RW'($urandom_range(15, 3));
    bus_write(ADR_TX_BDR, BUS_W'(sh_tx_bdr));
    fork
      begin
        for (int i = 0; i < N_TX; i++) begin
          b = DW'($urandom);
          tx_q.push_back(b);
          bus_write(ADR_TX_DAT, BUS_W'(b));
        end
      end
      capture_frames(N_TX, sh_tx_bdr);
    join
    test_end();

    test_begin("receive");
    sh_rx_bdr = RW'($urandom_range(15, 3));
    sh_rx_smp = sh_rx_bdr / 2;  // Mid bit
    bus_write(ADR_RX_BDR, BUS_W'(sh_rx_bdr));
    bus_write(ADR_RX_SMP, BUS_W'(sh_rx_smp));
    for (int f = 0; f < N_RX; f++) begin
      b = DW'($urandom);
      rx_q.push_back(b);
      send_frame(b, 1'b1);
      wait_rx_cnt(1);
      bus_read(ADR_RX_DAT, rd);
      check_dat("rx byte", rx_q.pop_front(), rd[DW-1:0]);
      if (f == N_RX / 2) begin
        send_frame(DW'($urandom), 1'b0);  // Framing error
        send_bit(1'b1, 2 * (sh_rx_bdr + 1));
        bus_read(ADR_RX_CNT, rd);
        check_cnt("rx count after bad stop", '0, rd[CW-1:0]);
      end
    end
    test_end();

    test_begin("fifo_load");
    sh_tx_bdr = '1;  // Slowest line so the FIFO fills
    sh_tx_irq = CW'($urandom_range(SZ, 0));
    bus_write(ADR_TX_BDR, BUS_W'(sh_tx_bdr));
    bus_write(ADR_TX_IRQ, BUS_W'(sh_tx_irq));
    tx_load = 0;
    for (int i = 0; i < SZ + 3; i++) begin
      bus_write(ADR_TX_DAT, $urandom);
      if (tx_load < SZ) tx_load++;  // Full FIFO drops it
      if (i == 0) tx_load--;        // Serializer takes first byte
      bus_read(ADR_TX_CNT, rd);
      check_cnt("tx count", CW'(tx_load), rd[CW-1:0]);
      check_bit("irq_tx", (tx_load < sh_tx_irq), irq_tx);
    end
    test_end();

    do_reset();  // Drop the slow frames still queued
    test_begin("loopback_irq");
    loop_en   = 1'b1;
    sh_tx_bdr = RW'($urandom_range(15, 3));
    sh_rx_bdr = sh_tx_bdr;
    sh_rx_smp = sh_tx_bdr / 2;
    sh_rx_irq = CW'($urandom_range(N_LOOP, 0));
    bus_write(ADR_TX_BDR, BUS_W'(sh_tx_bdr));
    bus_write(ADR_RX_BDR, BUS_W'(sh_rx_bdr));
    bus_write(ADR_RX_SMP, BUS_W'(sh_rx_smp));
    bus_write(ADR_RX_IRQ, BUS_W'(sh_rx_irq));
    for (int n = 1; n <= N_LOOP; n++) begin
      b = DW'($urandom);
      rx_q.push_back(b);
      bus_write(ADR_TX_DAT, BUS_W'(b));
      wait_rx_cnt(n);  // Load builds up with no reads
      check_bit("irq_rx", (n > sh_rx_irq), irq_rx);
    end
    // RX count and data offsets ignore writes
    bus_write(ADR_RX_CNT, $urandom);
    bus_write(ADR_RX_DAT, $urandom);
    bus_read(ADR_RX_CNT, rd);
    check_cnt("rx count after writes", CW'(N_LOOP), rd[CW-1:0]);
    for (int n = 0; n < N_LOOP; n++) begin
      bus_read(ADR_RX_DAT, rd);
      check_dat("rx byte", rx_q.pop_front(), rd[DW-1:0]);
    end
    bus_read(ADR_RX_DAT, rd);
    check_word("empty rx read", '0, rd);
    bus_read(ADR_RX_CNT, rd);
    check_cnt("rx count", '0, rd[CW-1:0]);
    check_bit("irq_rx", 1'b0, irq_rx);
    test_end();

    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== source/uart_peri.sv ====
`timescale 1ns/100ps

module uart_peri #(
  parameter int unsigned RW = 8,   // Bit period counter width
  parameter int unsigned DW = 8,   // Character width
  parameter int unsigned SZ = 16   // FIFO depth
)(
  input  logic                      tcb,
  input  logic                      rst_n,
  // Register bus
  input  logic                      bus_vld,
  input  logic                      bus_wen,
  input  logic [uart_pkg::ADR_W-1:0] bus_adr,
  input  logic [uart_pkg::BUS_W-1:0] bus_wdt,
  output logic [uart_pkg::BUS_W-1:0] bus_rdt,
  // Serial line
  input  logic                      uart_rxd,
  output logic                      uart_txd,
  // Interrupts
  output logic                      irq_tx,
  output logic                      irq_rx
);

  localparam int unsigned CW = $clog2(SZ+1);

  // Register block to FIFOs
  logic          tx_push, rx_pop;
  logic [DW-1:0] tx_wdat, rx_rdat;
  logic [CW-1:0] tx_cnt, rx_cnt;
  // Configuration
  logic [RW-1:0] tx_bdr, rx_bdr, rx_smp;
  // FIFO to line streams
  logic          tx_str_vld, tx_str_rdy;
  logic [DW-1:0] tx_str_dat;
  logic          rx_str_vld;  // Lost when RX FIFO full
  logic [DW-1:0] rx_str_dat;

  uart_regs #(.RW(RW), .DW(DW), .SZ(SZ)) regs (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_wdt (bus_wdt),
    .bus_rdt (bus_rdt),
    .tx_cnt  (tx_cnt),
    .rx_cnt  (rx_cnt),
    .rx_rdat (rx_rdat),
    .tx_push (tx_push),
    .tx_wdat (tx_wdat),
    .rx_pop  (rx_pop),
    .tx_bdr  (tx_bdr),
    .rx_bdr  (rx_bdr),
    .rx_smp  (rx_smp),
    .irq_tx  (irq_tx),
    .irq_rx  (irq_rx)
  );

  //////////////////////////////
  // TX channel
  //////////////////////////////

  uart_fifo #(.DW(DW), .SZ(SZ)) tx_fifo (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .sti_vld (tx_push),
    .sti_dat (tx_wdat),
    .sti_rdy (),
    .sto_vld (tx_str_vld),
    .sto_dat (tx_str_dat),
    .sto_rdy (tx_str_rdy),
    .cnt     (tx_cnt)
  );

  uart_ser #(.RW(RW), .DW(DW)) tx_ser (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .bdr     (tx_bdr),
    .str_vld (tx_str_vld),
    .str_dat (tx_str_dat),
    .str_rdy (tx_str_rdy),
    .txd     (uart_txd)
  );

  //////////////////////////////
  // RX channel
  //////////////////////////////

  uart_fifo #(.DW(DW), .SZ(SZ)) rx_fifo (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .sti_vld (rx_str_vld),
    .sti_dat (rx_str_dat),
    .sti_rdy (),
    .sto_vld (),
    .sto_dat (rx_rdat),
    .sto_rdy (rx_pop),
    .cnt     (rx_cnt)
  );

  uart_des #(.RW(RW), .DW(DW)) rx_des (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .bdr     (rx_bdr),
    .smp     (rx_smp),
    .rxd     (uart_rxd),
    .str_vld (rx_str_vld),
    .str_dat (rx_str_dat)
  );

endmodule

// ==== source/uart_des.sv ====
`timescale 1ns/100ps

module uart_des #(
  parameter int unsigned RW = 8,  // Bit period counter width
  parameter int unsigned DW = 8   // Character width
)(
  input  logic          tcb,
  input  logic          rst_n,
  input  logic [RW-1:0] bdr,      // Bit period minus one
  input  logic [RW-1:0] smp,      // Sample phase within bit
  // Serial input
  input  logic          rxd,
  // Character stream to RX FIFO
  output logic          str_vld,
  output logic [DW-1:0] str_dat
);

  import uart_pkg::*;

  localparam int unsigned IW = (DW > 1) ? $clog2(DW) : 1;

  uart_line_e    state;
  logic          rxd_m;    // First sync stage
  logic          rxd_s;    // Synchronized line
  logic          rxd_d;    // Previous synchronized value
  logic          fall;     // Start edge
  logic [RW-1:0] cnt;
  logic [IW-1:0] idx;
  logic [DW-1:0] sh;
  logic [DW:0]   sh_ins;   // Shifter with new bit on top
  logic          bit_end;
  logic          smp_hit;

  assign fall    = rxd_d & ~rxd_s;
  assign bit_end = (cnt == bdr);
  assign smp_hit = (cnt == smp);
  assign sh_ins  = {rxd_s, sh};
  assign str_dat = sh;  // Stable through stop bit

  //////////////////////////////
  // Input synchronizer
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rxd_m <= 1'b1;
      rxd_s <= 1'b1;
      rxd_d <= 1'b1;
    end else begin
      rxd_m <= rxd;
      rxd_s <= rxd_m;
      rxd_d <= rxd_s;
    end
  end

  // Bits arrive LSB first, shift in from the top
  always_ff @(posedge tcb) begin
    if ((state == LINE_DATA) && smp_hit) sh <= sh_ins[DW:1];
  end

  //////////////////////////////
  // Line FSM
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      state   <= LINE_IDLE;
      cnt     <= '0;
      idx     <= '0;
      str_vld <= 1'b0;
    end else begin
      str_vld <= 1'b0;  // Single cycle pulse
      if (state == LINE_IDLE) begin
        // Edge cycle counts as cycle 0 of start
        if (fall) begin
          state <= (bdr == '0) ? LINE_DATA : LINE_START;
          cnt   <= (bdr == '0) ? '0 : RW'(1);
          idx   <= '0;
        end
      end else begin
        cnt <= bit_end ? '0 : cnt + 1'b1;
        case (state)
          LINE_START: begin
            if (smp_hit && rxd_s) begin
              state <= LINE_IDLE;  // Glitch, not a start bit
            end else if (bit_end) begin
              state <= LINE_DATA;
              idx   <= '0;
            end
          end
          LINE_DATA: begin
            if (bit_end) begin
              if (idx == IW'(DW-1)) state <= LINE_STOP;
              else                  idx   <= idx + 1'b1;
            end
          end
          LINE_STOP: begin
            if (smp_hit) str_vld <= rxd_s;  // Framing error drops char
            if (bit_end) state <= LINE_IDLE;
          end
          default: state <= LINE_IDLE;
        endcase
      end
    end
  end

endmodule

// ==== source/uart_ser.sv ====
`timescale 1ns/100ps

module uart_ser #(
  parameter int unsigned RW = 8,  // Bit period counter width
  parameter int unsigned DW = 8   // Character width
)(
  input  logic          tcb,
  input  logic          rst_n,
  input  logic [RW-1:0] bdr,      // Bit period minus one
  // Character stream from TX FIFO
  input  logic          str_vld,
  input  logic [DW-1:0] str_dat,
  output logic          str_rdy,
  // Serial output
  output logic          txd
);

  import uart_pkg::*;

  localparam int unsigned IW = (DW > 1) ? $clog2(DW) : 1;  // Bit index width

  uart_line_e    state;
  logic [RW-1:0] cnt;      // Cycle within bit
  logic [IW-1:0] idx;      // Data bit index
  logic [DW-1:0] sh;       // Character shifter
  logic [DW-1:0] sh_nxt;
  logic          bit_end;  // Last cycle of a bit
  logic          load;     // Frame start

  assign bit_end = (cnt == bdr);
  // Accept in idle or at the very end of stop, frames chain with no gap
  assign str_rdy = (state == LINE_IDLE) || ((state == LINE_STOP) && bit_end);
  assign load    = str_vld & str_rdy;
  assign sh_nxt  = sh >> 1;

  always_ff @(posedge tcb) begin
    if (load) begin
      sh <= str_dat;
    end else if ((state == LINE_DATA) && bit_end) begin
      sh <= sh_nxt;  // Next bit into LSB
    end
  end

  //////////////////////////////
  // Line FSM
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      state <= LINE_IDLE;
      cnt   <= '0;
      idx   <= '0;
      txd   <= 1'b1;  // Line idles high
    end else begin
      if ((state == LINE_IDLE) || bit_end) cnt <= '0;
      else                                 cnt <= cnt + 1'b1;
      case (state)
        LINE_IDLE: begin
          if (load) begin
            state <= LINE_START;
            txd   <= 1'b0;
          end
        end
        LINE_START: begin
          if (bit_end) begin
            state <= LINE_DATA;
            idx   <= '0;
            txd   <= sh[0];  // LSB first
          end
        end
        LINE_DATA: begin
          if (bit_end) begin
            if (idx == IW'(DW-1)) begin
              state <= LINE_STOP;
              txd   <= 1'b1;
            end else begin
              idx <= idx + 1'b1;
              txd <= sh_nxt[0];
            end
          end
        end
        LINE_STOP: begin
          if (bit_end) begin
            if (load) begin
              state <= LINE_START;  // Back to back frame
              txd   <= 1'b0;
            end else begin
              state <= LINE_IDLE;
            end
          end
        end
        default: state <= LINE_IDLE;
      endcase
    end
  end

endmodule

// ==== source/uart_regs.sv ====
`timescale 1ns/100ps

module uart_regs #(
  parameter int unsigned RW = 8,   // Bit period counter width
  parameter int unsigned DW = 8,   // Character width
  parameter int unsigned SZ = 16,  // FIFO depth
  localparam int unsigned CW = $clog2(SZ+1)
)(
  input  logic                      tcb,
  input  logic                      rst_n,
  // Register bus
  input  logic                      bus_vld,
  input  logic                      bus_wen,
  input  logic [uart_pkg::ADR_W-1:0] bus_adr,
  input  logic [uart_pkg::BUS_W-1:0] bus_wdt,
  output logic [uart_pkg::BUS_W-1:0] bus_rdt,
  // FIFO side
  input  logic [CW-1:0]             tx_cnt,
  input  logic [CW-1:0]             rx_cnt,
  input  logic [DW-1:0]             rx_rdat,
  output logic                      tx_push,
  output logic [DW-1:0]             tx_wdat,
  output logic                      rx_pop,
  // Line configuration
  output logic [RW-1:0]             tx_bdr,
  output logic [RW-1:0]             rx_bdr,
  output logic [RW-1:0]             rx_smp,
  // Interrupts
  output logic                      irq_tx,
  output logic                      irq_rx
);

  import uart_pkg::*;

  uart_adr_e     adr;     // Decoded offset
  logic [CW-1:0] tx_irq;  // TX low water level
  logic [CW-1:0] rx_irq;  // RX high water level

  assign adr = uart_adr_e'(bus_adr);

  //////////////////////////////
  // Configuration writes
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      tx_bdr <= '0;
      tx_irq <= '0;
      rx_bdr <= '0;
      rx_smp <= '0;
      rx_irq <= '0;
    end else if (bus_vld && bus_wen) begin
      case (adr)
        ADR_TX_BDR: tx_bdr <= bus_wdt[RW-1:0];  // Upper bits dropped
        ADR_TX_IRQ: tx_irq <= bus_wdt[CW-1:0];
        ADR_RX_BDR: rx_bdr <= bus_wdt[RW-1:0];
        ADR_RX_SMP: rx_smp <= bus_wdt[RW-1:0];
        ADR_RX_IRQ: rx_irq <= bus_wdt[CW-1:0];
        default:    ;  // Data and count offsets, unmapped
      endcase
    end
  end

  //////////////////////////////
  // FIFO strobes
  //////////////////////////////

  // Full FIFO ignores the push, so the byte is lost
  assign tx_push = bus_vld & bus_wen & (adr == ADR_TX_DAT);
  assign tx_wdat = bus_wdt[DW-1:0];

  // Empty FIFO ignores the pop
  assign rx_pop  = bus_vld & ~bus_wen & (adr == ADR_RX_DAT);

  //////////////////////////////
  // Read multiplexer
  //////////////////////////////

  always_comb begin
    bus_rdt = '0;  // Zero extension and unmapped reads
    case (adr)
      ADR_TX_CNT: bus_rdt[CW-1:0] = tx_cnt;
      ADR_TX_BDR: bus_rdt[RW-1:0] = tx_bdr;
      ADR_TX_IRQ: bus_rdt[CW-1:0] = tx_irq;
      ADR_RX_DAT: begin
        // Head of FIFO, zero when nothing stored
        if (rx_cnt != '0) bus_rdt[DW-1:0] = rx_rdat;
      end
      ADR_RX_CNT: bus_rdt[CW-1:0] = rx_cnt;
      ADR_RX_BDR: bus_rdt[RW-1:0] = rx_bdr;
      ADR_RX_SMP: bus_rdt[RW-1:0] = rx_smp;
      ADR_RX_IRQ: bus_rdt[CW-1:0] = rx_irq;
      default:    ;  // TX data reads as zero
    endcase
  end

  // Level interrupts
  assign irq_tx = (tx_cnt < tx_irq);  // TX running low
  assign irq_rx = (rx_cnt > rx_irq);  // RX filling up

endmodule

// ==== source/uart_fifo.sv ====
`timescale 1ns/100ps

module uart_fifo #(
  parameter int unsigned DW = 8,   // Entry width
  parameter int unsigned SZ = 16,  // Number of entries
  localparam int unsigned CW = $clog2(SZ+1)
)(
  input  logic          tcb,
  input  logic          rst_n,
  // Input stream
  input  logic          sti_vld,
  input  logic [DW-1:0] sti_dat,
  output logic          sti_rdy,
  // Output stream
  output logic          sto_vld,
  output logic [DW-1:0] sto_dat,
  input  logic          sto_rdy,
  // Load
  output logic [CW-1:0] cnt
);

  localparam int unsigned AW = (SZ > 1) ? $clog2(SZ) : 1;  // Pointer width

  logic [DW-1:0] mem [SZ];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          push;
  logic          pop;

  assign sti_rdy = (cnt != CW'(SZ));  // Not full
  assign sto_vld = (cnt != '0);       // Not empty
  assign push    = sti_vld & sti_rdy;
  assign pop     = sto_vld & sto_rdy;

  // Head read straight out of storage
  assign sto_dat = mem[rd_ptr];

  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= sti_dat;
  end

  //////////////////////////////
  // Pointers and load
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      // Wrap at depth, works for any SZ
      if (push) wr_ptr <= (wr_ptr == AW'(SZ-1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == AW'(SZ-1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop keeps the load
      if (push && !pop) begin
        cnt <= cnt + 1'b1;
      end else if (pop && !push) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

// ==== source/uart_pkg.sv ====
package uart_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int unsigned ADR_W = 6;   // Byte address, one 64 byte window
  localparam int unsigned BUS_W = 32;  // Read and write data word

  //////////////////////////////
  // Register map
  //////////////////////////////

  typedef enum logic [ADR_W-1:0] {
    // TX channel
    ADR_TX_DAT = 6'h00,  // TX data, write only
    ADR_TX_CNT = 6'h04,  // TX FIFO load
    ADR_TX_BDR = 6'h08,  // TX bit period minus one
    ADR_TX_IRQ = 6'h10,  // TX interrupt level
    // RX channel
    ADR_RX_DAT = 6'h20,  // RX data, read pops
    ADR_RX_CNT = 6'h24,  // RX FIFO load
    ADR_RX_BDR = 6'h28,  // RX bit period minus one
    ADR_RX_SMP = 6'h2C,  // RX sample phase
    ADR_RX_IRQ = 6'h30   // RX interrupt level
  } uart_adr_e;

  //////////////////////////////
  // Serial line state
  //////////////////////////////

  typedef enum logic [1:0] {
    LINE_IDLE  = 2'd0,  // Line high, waiting
    LINE_START = 2'd1,  // Start bit
    LINE_DATA  = 2'd2,  // Character bits, LSB first
    LINE_STOP  = 2'd3   // Single stop bit
  } uart_line_e;

endpackage
